/* Makefile */
# Verilator flow for the AXI ID remapper.
TOP = id_remap_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f id_remap.f --top-module $(TOP)

# The run passes only if the log holds no failure and does hold the pass line.
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f id_remap.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/id_remap_consts.svh */
// Size constants of the AXI ID remapper, included by the package and by any file using the sizes.
`ifndef ID_REMAP_CONSTS_SVH
`define ID_REMAP_CONSTS_SVH

// Width of the wide, sparsely used IDs on the upstream side.
`define ID_REMAP_IN_ID_W 6

// Width of the narrow IDs on the downstream side.
// It must be at least the table index width, because the index is the output ID.
`define ID_REMAP_OUT_ID_W 3

// Number of table entries per direction.
// This is the number of distinct input IDs that may be in flight at once.
`define ID_REMAP_UNIQ_IDS 4
`define ID_REMAP_IDX_W 2

// In-flight transactions allowed per input ID, and the counter width that holds that number.
`define ID_REMAP_MAX_TXNS 3
`define ID_REMAP_CNT_W 2

// Payload widths that pass through unchanged.
`define ID_REMAP_ADDR_W 16
`define ID_REMAP_DATA_W 16

`endif

/* hdl/id_remap_issue.sv */
// Issue controller of one direction: admits or stalls a request and holds its index downstream.
`timescale 1ns/1ps
`default_nettype none

module id_remap_issue
  import id_remap_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  // Upstream request valid and downstream ready.
  input  logic in_valid_i,
  input  logic out_ready_i,
  // Table lookup of the offered input ID.
  input  logic exists_i,
  input  idx_t exists_idx_i,
  input  logic exists_full_i,
  // Free entry search of the table.
  input  logic full_i,
  input  idx_t free_idx_i,
  // Handshake outputs on both sides.
  output logic in_ready_o,
  output logic out_valid_o,
  // Table push and the index the request is issued under.
  output logic push_o,
  output idx_t out_idx_o
);

  issue_state_e state_q;
  issue_state_e state_d;

  // Index of a request that was pushed but is still waiting for downstream ready.
  idx_t idx_q;
  idx_t idx_d;

  // Room for the request.
  // A known ID needs space in its own counter, a new ID needs a free entry.
  logic admit;

  assign admit = exists_i ? !exists_full_i : !full_i;

  always_comb begin
    state_d     = state_q;
    idx_d       = idx_q;
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    push_o      = 1'b0;
    out_idx_o   = idx_q;

    case (state_q)
      ISSUE_READY: begin
        if (in_valid_i && admit) begin
          // Reuse the index of an ID in flight so that its ordering is kept.
          out_idx_o   = exists_i ? exists_idx_i : free_idx_i;
          out_valid_o = 1'b1;
          // The push happens on the first offer, even if downstream is not ready yet.
          push_o      = 1'b1;
          in_ready_o  = out_ready_i;
          if (!out_ready_i) begin
            idx_d   = out_idx_o;
            state_d = ISSUE_HOLD;
          end
        end
      end

      ISSUE_HOLD: begin
        // Keep offering the pushed request with the same index until it is taken.
        // No lookup is considered here, so the table is not pushed twice.
        out_valid_o = 1'b1;
        in_ready_o  = out_ready_i;
        if (out_ready_i) begin
          state_d = ISSUE_READY;
        end
      end

      default: begin
        state_d = ISSUE_READY;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ISSUE_READY;
    end else begin
      state_q <= state_d;
    end
  end

  // The held index is only read in ISSUE_HOLD, which is always entered with a fresh value.
  always_ff @(posedge clk_i) begin
    idx_q <= idx_d;
  end

endmodule

`default_nettype wire

/* hdl/id_remap_pkg.sv */
// Shared types of the AXI ID remapper; modules and the testbench import them with a wildcard.
`default_nettype none

`include "id_remap_consts.svh"

package id_remap_pkg;

  // IDs on both sides of the remapper.
  typedef logic [`ID_REMAP_IN_ID_W-1:0]  in_id_t;
  typedef logic [`ID_REMAP_OUT_ID_W-1:0] out_id_t;

  // Table bookkeeping.
  // The index of an entry is also the narrow ID it is issued under.
  typedef logic [`ID_REMAP_IDX_W-1:0]    idx_t;
  typedef logic [`ID_REMAP_CNT_W-1:0]    cnt_t;
  typedef logic [`ID_REMAP_UNIQ_IDS-1:0] field_t;

  // Payload that travels through the remapper untouched.
  typedef logic [`ID_REMAP_ADDR_W-1:0]   addr_t;
  typedef logic [`ID_REMAP_DATA_W-1:0]   data_t;
  typedef logic [1:0]                    resp_t;

  // States of the per-direction issue controller.
  // In ISSUE_HOLD a request has been pushed but not yet accepted downstream.
  typedef enum logic {
    ISSUE_READY = 1'b0,
    ISSUE_HOLD  = 1'b1
  } issue_state_e;

endpackage

`default_nettype wire

/* hdl/id_remap_table.sv */
// Remap table of one direction: maps in-flight input IDs to table indexes and counts their bursts.
`timescale 1ns/1ps
`default_nettype none

`include "id_remap_consts.svh"

module id_remap_table
  import id_remap_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  // Push one transaction for an input ID under the given index.
  input  logic   push_i,
  input  in_id_t push_in_id_i,
  input  idx_t   push_idx_i,
  // Lookup of the input ID currently offered upstream.
  input  in_id_t lookup_in_id_i,
  // Pop one transaction when its last response is transferred.
  input  logic   pop_i,
  input  idx_t   pop_idx_i,
  // Free entry search.
  output logic   full_o,
  output idx_t   free_idx_o,
  // Lookup results.
  output logic   exists_o,
  output idx_t   exists_idx_o,
  output logic   exists_full_o,
  // Input ID stored under the popped index.
  output in_id_t pop_in_id_o
);

  // Each entry holds an input ID and the number of its transactions in flight.
  // An entry with a zero counter is free and its stored ID has no meaning.
  in_id_t id_q  [`ID_REMAP_UNIQ_IDS];
  cnt_t   cnt_q [`ID_REMAP_UNIQ_IDS];
  cnt_t   cnt_d [`ID_REMAP_UNIQ_IDS];

  // One bit per entry for the free search and for the ID match.
  field_t free;
  field_t match;

  always_comb begin
    for (int i = 0; i < `ID_REMAP_UNIQ_IDS; i++) begin
      free[i]  = (cnt_q[i] == '0);
      // Only busy entries can match, so a stale ID in a free entry is ignored.
      match[i] = (cnt_q[i] != '0) && (id_q[i] == lookup_in_id_i);
    end
  end

  // Lowest free index.
  // The scan runs downwards so that the lowest free entry is the last one written.
  always_comb begin
    free_idx_o = '0;
    for (int i = `ID_REMAP_UNIQ_IDS - 1; i >= 0; i--) begin
      if (free[i]) begin
        free_idx_o = idx_t'(i);
      end
    end
  end

  assign full_o = ~|free;

  // Index that already carries the looked-up ID.
  // At most one entry can match, because a known ID is always pushed to its own entry.
  always_comb begin
    exists_idx_o = '0;
    for (int i = `ID_REMAP_UNIQ_IDS - 1; i >= 0; i--) begin
      if (match[i]) begin
        exists_idx_o = idx_t'(i);
      end
    end
  end

  assign exists_o = |match;

  // The matched entry has reached its limit and cannot take another transaction.
  assign exists_full_o = exists_o &&
                         (cnt_q[exists_idx_o] == cnt_t'(`ID_REMAP_MAX_TXNS));

  // Responses carry the index back; the table turns it into the original input ID.
  assign pop_in_id_o = id_q[pop_idx_i];

  // Counter update.
  // A push and a pop to the same entry in one cycle leave its counter unchanged.
  always_comb begin
    for (int i = 0; i < `ID_REMAP_UNIQ_IDS; i++) begin
      cnt_d[i] = cnt_q[i];
      if (push_i && (push_idx_i == idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] + cnt_t'(1);
      end
      if (pop_i && (pop_idx_i == idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `ID_REMAP_UNIQ_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `ID_REMAP_UNIQ_IDS; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // The input ID is written on every push.
  // For an entry that is already busy this rewrites the same value.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[push_idx_i] <= push_in_id_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/id_remap_top.sv */
// Top level of the AXI ID remapper; connects upstream AR/R and AW/B to their downstream ports.
`timescale 1ns/1ps
`default_nettype none

`include "id_remap_consts.svh"

module id_remap_top
  import id_remap_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  // AR upstream.
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  input  in_id_t  ar_id_i,
  input  addr_t   ar_addr_i,
  // AR downstream.
  output logic    m_ar_valid_o,
  input  logic    m_ar_ready_i,
  output out_id_t m_ar_id_o,
  output addr_t   m_ar_addr_o,
  // AW upstream.
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  in_id_t  aw_id_i,
  input  addr_t   aw_addr_i,
  // AW downstream.
  output logic    m_aw_valid_o,
  input  logic    m_aw_ready_i,
  output out_id_t m_aw_id_o,
  output addr_t   m_aw_addr_o,
  // R downstream.
  input  logic    m_r_valid_i,
  output logic    m_r_ready_o,
  input  out_id_t m_r_id_i,
  input  data_t   m_r_data_i,
  input  resp_t   m_r_resp_i,
  input  logic    m_r_last_i,
  // R upstream.
  output logic    r_valid_o,
  input  logic    r_ready_i,
  output in_id_t  r_id_o,
  output data_t   r_data_o,
  output resp_t   r_resp_o,
  output logic    r_last_o,
  // B downstream.
  input  logic    m_b_valid_i,
  output logic    m_b_ready_o,
  input  out_id_t m_b_id_i,
  input  resp_t   m_b_resp_i,
  // B upstream.
  output logic    b_valid_o,
  input  logic    b_ready_i,
  output in_id_t  b_id_o,
  output resp_t   b_resp_o
);

  // Table and controller signals of the read direction.
  logic rd_full;
  idx_t rd_free_idx;
  logic rd_exists;
  idx_t rd_exists_idx;
  logic rd_exists_full;
  logic rd_push;
  idx_t rd_idx;
  logic rd_pop;

  // The same set for the write direction.
  logic wr_full;
  idx_t wr_free_idx;
  logic wr_exists;
  idx_t wr_exists_idx;
  logic wr_exists_full;
  logic wr_push;
  idx_t wr_idx;
  logic wr_pop;

  // Addresses pass through untouched.
  assign m_ar_addr_o = ar_addr_i;
  assign m_aw_addr_o = aw_addr_i;

  // Output IDs are the table index with zeros prepended.
  assign m_ar_id_o = {{(`ID_REMAP_OUT_ID_W - `ID_REMAP_IDX_W){1'b0}}, rd_idx};
  assign m_aw_id_o = {{(`ID_REMAP_OUT_ID_W - `ID_REMAP_IDX_W){1'b0}}, wr_idx};

  // Responses pass straight through apart from the ID, which the tables translate back.
  assign r_valid_o   = m_r_valid_i;
  assign m_r_ready_o = r_ready_i;
  assign r_data_o    = m_r_data_i;
  assign r_resp_o    = m_r_resp_i;
  assign r_last_o    = m_r_last_i;
  assign b_valid_o   = m_b_valid_i;
  assign m_b_ready_o = b_ready_i;
  assign b_resp_o    = m_b_resp_i;

  // A read burst completes with its last beat; a write completes with its single B.
  assign rd_pop = m_r_valid_i && r_ready_i && m_r_last_i;
  assign wr_pop = m_b_valid_i && b_ready_i;

  id_remap_table i_rd_table (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .push_i         (rd_push),
    .push_in_id_i   (ar_id_i),
    .push_idx_i     (rd_idx),
    .lookup_in_id_i (ar_id_i),
    .pop_i          (rd_pop),
    .pop_idx_i      (m_r_id_i[`ID_REMAP_IDX_W-1:0]),
    .full_o         (rd_full),
    .free_idx_o     (rd_free_idx),
    .exists_o       (rd_exists),
    .exists_idx_o   (rd_exists_idx),
    .exists_full_o  (rd_exists_full),
    .pop_in_id_o    (r_id_o)
  );

  id_remap_table i_wr_table (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .push_i         (wr_push),
    .push_in_id_i   (aw_id_i),
    .push_idx_i     (wr_idx),
    .lookup_in_id_i (aw_id_i),
    .pop_i          (wr_pop),
    .pop_idx_i      (m_b_id_i[`ID_REMAP_IDX_W-1:0]),
    .full_o         (wr_full),
    .free_idx_o     (wr_free_idx),
    .exists_o       (wr_exists),
    .exists_idx_o   (wr_exists_idx),
    .exists_full_o  (wr_exists_full),
    .pop_in_id_o    (b_id_o)
  );

  id_remap_issue i_rd_issue (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (ar_valid_i),
    .out_ready_i   (m_ar_ready_i),
    .exists_i      (rd_exists),
    .exists_idx_i  (rd_exists_idx),
    .exists_full_i (rd_exists_full),
    .full_i        (rd_full),
    .free_idx_i    (rd_free_idx),
    .in_ready_o    (ar_ready_o),
    .out_valid_o   (m_ar_valid_o),
    .push_o        (rd_push),
    .out_idx_o     (rd_idx)
  );

  id_remap_issue i_wr_issue (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (aw_valid_i),
    .out_ready_i   (m_aw_ready_i),
    .exists_i      (wr_exists),
    .exists_idx_i  (wr_exists_idx),
    .exists_full_i (wr_exists_full),
    .full_i        (wr_full),
    .free_idx_i    (wr_free_idx),
    .in_ready_o    (aw_ready_o),
    .out_valid_o   (m_aw_valid_o),
    .push_o        (wr_push),
    .out_idx_o     (wr_idx)
  );

endmodule

`default_nettype wire

/* id_remap.f */
+incdir+hdl
hdl/id_remap_pkg.sv
hdl/id_remap_table.sv
hdl/id_remap_issue.sv
hdl/id_remap_top.sv
verification/id_remap_sva.sv
verification/id_remap_tb.sv

/* verification/id_remap_sva.sv */
// Concurrent assertions on the remapper handshakes, bound to the top level of the design.
`timescale 1ns/1ps
`default_nettype none

module id_remap_sva
  import id_remap_pkg::*;
(
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    ar_valid_i,
  input logic    ar_ready_o,
  input logic    m_ar_valid_o,
  input logic    m_ar_ready_i,
  input out_id_t m_ar_id_o,
  input logic    aw_valid_i,
  input logic    aw_ready_o,
  input logic    m_aw_valid_o,
  input logic    m_aw_ready_i,
  input out_id_t m_aw_id_o,
  input logic    r_valid_o,
  input logic    r_ready_i,
  input in_id_t  r_id_o,
  input logic    b_valid_o,
  input logic    b_ready_i,
  input in_id_t  b_id_o
);

  // An address transfer upstream happens in the same cycle as the one downstream.
  a_ar_xfer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ar_valid_i && ar_ready_o) == (m_ar_valid_o && m_ar_ready_i))
    else $error("AR transfers upstream and downstream differ");
  a_aw_xfer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (aw_valid_i && aw_ready_o) == (m_aw_valid_o && m_aw_ready_i))
    else $error("AW transfers upstream and downstream differ");

  // A refused response keeps its translated input ID.
  // The entry it points to is busy, so no push may give it another ID.
  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_id_o)))
    else $error("R ID changed under back-pressure");
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (b_valid_o && !b_ready_i) |=> (b_valid_o && $stable(b_id_o)))
    else $error("B ID changed under back-pressure");

  // A refused offer stays valid with the same output ID.
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_ar_valid_o && !m_ar_ready_i) |=> (m_ar_valid_o && $stable(m_ar_id_o)))
    else $error("AR offer changed under back-pressure");
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_aw_valid_o && !m_aw_ready_i) |=> (m_aw_valid_o && $stable(m_aw_id_o)))
    else $error("AW offer changed under back-pressure");

endmodule

bind id_remap_top id_remap_sva i_id_remap_sva (.*);

`default_nettype wire

/* verification/id_remap_tb.sv */
// Random testbench of the AXI ID remapper, checked against a table model; run it as the top.
`timescale 1ns/1ps
`default_nettype none

`include "id_remap_consts.svh"

module id_remap_tb
  import id_remap_pkg::*;
();

  // Requests per direction in each traffic test.
  localparam int N_TXNS = 150;
  localparam int N_TRAFFIC_TESTS = 3;
  // Every request of both directions gets 50 cycles before the run is declared stuck.
  localparam int WATCHDOG_CYCLES = N_TRAFFIC_TESTS * 2 * N_TXNS * 50;

  // DUT ports, named as on the top level.
  logic    clk_i = 1'b0;
  logic    rst_n_i;
  logic    ar_valid_i, ar_ready_o, m_ar_valid_o, m_ar_ready_i;
  in_id_t  ar_id_i;
  out_id_t m_ar_id_o;
  addr_t   ar_addr_i, m_ar_addr_o;
  logic    aw_valid_i, aw_ready_o, m_aw_valid_o, m_aw_ready_i;
  in_id_t  aw_id_i;
  out_id_t m_aw_id_o;
  addr_t   aw_addr_i, m_aw_addr_o;
  logic    m_r_valid_i, m_r_ready_o, m_r_last_i, r_valid_o, r_ready_i, r_last_o;
  out_id_t m_r_id_i;
  in_id_t  r_id_o;
  data_t   m_r_data_i, r_data_o;
  resp_t   m_r_resp_i, r_resp_o;
  logic    m_b_valid_i, m_b_ready_o, b_valid_o, b_ready_i;
  out_id_t m_b_id_i;
  in_id_t  b_id_o;
  resp_t   m_b_resp_i, b_resp_o;

  // Model of both tables; index 0 is the read direction and 1 the write direction.
  in_id_t m_id    [2][`ID_REMAP_UNIQ_IDS];
  int     m_cnt   [2][`ID_REMAP_UNIQ_IDS];
  // Requests taken downstream whose response has not been sent yet.
  int     out_cnt [2][`ID_REMAP_UNIQ_IDS];
  logic   hold    [2];
  int     hold_idx[2];
  int     acc     [2];
  int     stalls  [2];
  // Transfers at the coming edge, in the order AR, AW, R, B.
  logic   done    [4];
  // Response agents: the index being answered, or -1 when idle.
  int     r_idx;
  int     r_beats;
  int     b_idx;
  // Six sparse IDs for four entries, so the table runs full now and then.
  in_id_t id_pool [6];
  int     err_cnt;
  int     chk_cnt;
  int     test_cnt;

  always #4 clk_i = ~clk_i;

  id_remap_top i_id_remap_top (.*);

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic logic chance(input int pct);
    return ($urandom % 100) < pct;
  endfunction

  function automatic in_id_t pick_id();
    int k;
    k = int'($urandom % 6);
    return id_pool[k];
  endfunction

  // Random index with responses owed, so answers come back out of order across IDs.
  function automatic int pick_busy(input int d);
    int start;
    int j;
    start = int'($urandom % `ID_REMAP_UNIQ_IDS);
    for (int i = 0; i < `ID_REMAP_UNIQ_IDS; i++) begin
      j = (start + i) % `ID_REMAP_UNIQ_IDS;
      if (out_cnt[d][j] > 0) return j;
    end
    return -1;
  endfunction

  function automatic logic responses_pending();
    logic busy;
    busy = m_r_valid_i || m_b_valid_i || (r_idx >= 0) || (b_idx >= 0);
    for (int i = 0; i < `ID_REMAP_UNIQ_IDS; i++) begin
      busy = busy || (out_cnt[0][i] > 0) || (out_cnt[1][i] > 0);
    end
    return busy;
  endfunction

  // Admission rule of one direction, evaluated on the model state before the edge.
  task automatic check_issue(input int d, input string ch, input logic vld, input in_id_t id,
                             input logic dn_rdy, input logic up_rdy, input logic dn_vld,
                             input out_id_t dn_id);
    int   found;
    int   free_idx;
    int   idx;
    logic exp_vld;
    found    = -1;
    free_idx = -1;
    idx      = hold_idx[d];
    exp_vld  = hold[d];
    for (int i = `ID_REMAP_UNIQ_IDS - 1; i >= 0; i--) begin
      if (m_cnt[d][i] != 0 && m_id[d][i] == id) found = i;
      if (m_cnt[d][i] == 0) free_idx = i;
    end
    // A held request was counted at its first offer and is only offered again.
    if (!hold[d] && vld) begin
      if (found >= 0) begin
        exp_vld = (m_cnt[d][found] < `ID_REMAP_MAX_TXNS);
        idx     = found;
      end else begin
        exp_vld = (free_idx >= 0);
        idx     = free_idx;
      end
      if (exp_vld) begin
        m_cnt[d][idx]++;
        m_id[d][idx] = id;
      end else begin
        stalls[d]++;
      end
    end
    compare_value({"m_", ch, "_valid_o"}, 32'(dn_vld), 32'(exp_vld));
    compare_value({ch, "_ready_o"}, 32'(up_rdy), 32'(exp_vld && dn_rdy));
    if (exp_vld) compare_value({"m_", ch, "_id_o"}, 32'(dn_id), 32'(idx));
    done[d]     = exp_vld && dn_rdy;
    hold[d]     = exp_vld && !dn_rdy;
    hold_idx[d] = idx;
    if (done[d]) begin
      out_cnt[d][idx]++;
      acc[d]++;
    end
  endtask

  // One clock cycle: drive on the falling edge, then check 2 ns before the rising edge.
  task automatic run_cycle(input int target, input int p_req, input int p_ardy,
                           input int p_resp, input int p_rrdy);
    @(negedge clk_i);
    // A request drops after its transfer and may be replaced at once.
    if (done[0]) ar_valid_i = 1'b0;
    if (!ar_valid_i && acc[0] < target && chance(p_req)) begin
      ar_valid_i = 1'b1;
      ar_id_i    = pick_id();
      ar_addr_i  = addr_t'($urandom);
    end
    if (done[1]) aw_valid_i = 1'b0;
    if (!aw_valid_i && acc[1] < target && chance(p_req)) begin
      aw_valid_i = 1'b1;
      aw_id_i    = pick_id();
      aw_addr_i  = addr_t'($urandom);
    end
    m_ar_ready_i = chance(p_ardy);
    m_aw_ready_i = chance(p_ardy);
    // One R burst at a time, 1 to 3 beats long.
    if (done[2]) m_r_valid_i = 1'b0;
    if (!m_r_valid_i) begin
      if (r_idx < 0 && chance(p_resp)) begin
        r_idx   = pick_busy(0);
        r_beats = 1 + int'($urandom % 3);
      end
      if (r_idx >= 0) begin
        m_r_valid_i = 1'b1;
        m_r_id_i    = out_id_t'(r_idx);
        m_r_data_i  = data_t'($urandom);
        m_r_resp_i  = resp_t'($urandom);
        m_r_last_i  = (r_beats == 1);
      end
    end
    r_ready_i = chance(p_rrdy);
    if (done[3]) m_b_valid_i = 1'b0;
    if (!m_b_valid_i && b_idx < 0 && chance(p_resp)) b_idx = pick_busy(1);
    if (!m_b_valid_i && b_idx >= 0) begin
      m_b_valid_i = 1'b1;
      m_b_id_i    = out_id_t'(b_idx);
      m_b_resp_i  = resp_t'($urandom);
    end
    b_ready_i = chance(p_rrdy);

    #2;
    check_issue(0, "ar", ar_valid_i, ar_id_i, m_ar_ready_i, ar_ready_o, m_ar_valid_o, m_ar_id_o);
    check_issue(1, "aw", aw_valid_i, aw_id_i, m_aw_ready_i, aw_ready_o, m_aw_valid_o, m_aw_id_o);
    compare_value("m_ar_addr_o", 32'(m_ar_addr_o), 32'(ar_addr_i));
    compare_value("m_aw_addr_o", 32'(m_aw_addr_o), 32'(aw_addr_i));
    compare_value("r_valid_o", 32'(r_valid_o), 32'(m_r_valid_i));
    compare_value("m_r_ready_o", 32'(m_r_ready_o), 32'(r_ready_i));
    compare_value("r_data_o", 32'(r_data_o), 32'(m_r_data_i));
    compare_value("r_resp_o", 32'(r_resp_o), 32'(m_r_resp_i));
    compare_value("r_last_o", 32'(r_last_o), 32'(m_r_last_i));
    if (m_r_valid_i) compare_value("r_id_o", 32'(r_id_o), 32'(m_id[0][r_idx]));
    compare_value("b_valid_o", 32'(b_valid_o), 32'(m_b_valid_i));
    compare_value("m_b_ready_o", 32'(m_b_ready_o), 32'(b_ready_i));
    compare_value("b_resp_o", 32'(b_resp_o), 32'(m_b_resp_i));
    if (m_b_valid_i) compare_value("b_id_o", 32'(b_id_o), 32'(m_id[1][b_idx]));
    // Pops follow the issue checks, because a freed entry is only free after the edge.
    done[2] = m_r_valid_i && r_ready_i;
    done[3] = m_b_valid_i && b_ready_i;
    if (done[2]) begin
      r_beats--;
      if (m_r_last_i) begin
        m_cnt[0][r_idx]--;
        out_cnt[0][r_idx]--;
        r_idx = -1;
      end
    end
    if (done[3]) begin
      m_cnt[1][b_idx]--;
      out_cnt[1][b_idx]--;
      b_idx = -1;
    end
  endtask

  // With n at zero no request is issued and the test drains all open responses.
  task automatic run_test(input string name, input int n, input int p_req, input int p_ardy,
                          input int p_resp, input int p_rrdy);
    int err_base;
    err_base = err_cnt;
    for (int d = 0; d < 2; d++) begin
      acc[d]    = 0;
      stalls[d] = 0;
    end
    if (n > 0) begin
      while (acc[0] < n || acc[1] < n) run_cycle(n, p_req, p_ardy, p_resp, p_rrdy);
    end else begin
      while (responses_pending()) run_cycle(0, p_req, p_ardy, p_resp, p_rrdy);
    end
    test_cnt++;
    $display("%s: reads %0d, writes %0d, stalls %0d/%0d, errors %0d",
             name, acc[0], acc[1], stalls[0], stalls[1], err_cnt - err_base);
  endtask

  initial begin
    void'($urandom(32'hbb04_822f));
    id_pool = '{6'h03, 6'h0c, 6'h15, 6'h22, 6'h2f, 6'h3e};
    rst_n_i = 1'b0;
    {ar_valid_i, m_ar_ready_i, aw_valid_i, m_aw_ready_i} = '0;
    {ar_id_i, aw_id_i, ar_addr_i, aw_addr_i} = '0;
    {m_r_valid_i, m_r_last_i, r_ready_i, m_b_valid_i, b_ready_i} = '0;
    {m_r_id_i, m_r_data_i, m_r_resp_i, m_b_id_i, m_b_resp_i} = '0;
    for (int d = 0; d < 2; d++) begin
      hold[d]     = 1'b0;
      hold_idx[d] = 0;
      for (int i = 0; i < `ID_REMAP_UNIQ_IDS; i++) begin
        m_id[d][i]    = '0;
        m_cnt[d][i]   = 0;
        out_cnt[d][i] = 0;
      end
    end
    done     = '{4{1'b0}};
    r_idx    = -1;
    r_beats  = 0;
    b_idx    = -1;
    err_cnt  = 0;
    chk_cnt  = 0;
    test_cnt = 0;

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #2;
    compare_value("m_ar_valid_o", 32'(m_ar_valid_o), 32'(0));
    compare_value("m_aw_valid_o", 32'(m_aw_valid_o), 32'(0));
    compare_value("ar_ready_o", 32'(ar_ready_o), 32'(0));
    compare_value("aw_ready_o", 32'(aw_ready_o), 32'(0));
    test_cnt++;
    $display("reset: errors %0d", err_cnt);

    run_test("mixed traffic", N_TXNS, 70, 70, 60, 80);
    // Slow responses fill the counters and the table, so requests must stall.
    run_test("slow responses", N_TXNS, 90, 80, 15, 50);
    if (stalls[0] == 0 || stalls[1] == 0) begin
      err_cnt++;
      $display("Slow responses did not stall a request in both directions");
    end
    run_test("downstream back-pressure", N_TXNS, 80, 20, 50, 60);
    run_test("drain", 0, 0, 100, 100, 100);

    $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
